// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // ALU operation codes
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_XOR = 3'd4;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } sb_fmt_t;

    // Same word, register view or store/branch view
    typedef union packed {
        r_fmt_t  r;
        sb_fmt_t sb;
    } inst_word_u;

endpackage

// File: source/core_cfg_pkg.sv
package core_cfg_pkg;

    // Word-address widths of the two memories
    localparam int IMEM_AW = 8;
    localparam int DMEM_AW = 8;

    // 64 two-bit counters
    localparam int BHT_AW = 6;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

endpackage

// File: source/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  logic               imem_we,
    input  logic [IMEM_AW-1:0] imem_addr,
    input  logic [31:0]        imem_data,
    input  logic               bht_we,
    input  logic [BHT_AW-1:0]  bht_addr,
    input  logic [1:0]         bht_data,
    input  logic               stall,
    input  logic               redirect,
    input  logic [31:0]        redirect_pc,
    input  logic               bht_upd,
    input  logic [BHT_AW-1:0]  bht_upd_idx,
    input  logic               bht_upd_taken,
    output logic [31:0]        if_inst,
    output logic [31:0]        if_pc,
    output logic               if_pred_taken
);

    logic [31:0] imem [2**IMEM_AW];
    logic [1:0]  bht [2**BHT_AW];
    logic [31:0] pc;
    inst_word_u  f_inst;
    logic [1:0]  ctr;
    logic [31:0] b_imm;
    logic        pred;
    logic [31:0] next_pc;

    assign f_inst = imem[pc[IMEM_AW+1:2]];
    assign ctr    = bht[pc[BHT_AW+1:2]];

    // Pre-decode the branch target straight from the fetched word
    assign b_imm = {{20{f_inst.sb.imm_hi[6]}}, f_inst.sb.imm_lo[0],
                    f_inst.sb.imm_hi[5:0], f_inst.sb.imm_lo[4:1], 1'b0};
    assign pred    = (f_inst.sb.opcode == OPC_BRANCH) && ctr[1];
    assign next_pc = pred ? pc + b_imm : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_data;
        end
    end

    // Init port wins over a resolved-branch update
    always_ff @(posedge clk) begin
        if (bht_we) begin
            bht[bht_addr] <= bht_data;
        end else if (bht_upd) begin
            if (bht_upd_taken && bht[bht_upd_idx] != 2'd3) begin
                bht[bht_upd_idx] <= bht[bht_upd_idx] + 2'd1;
            end else if (!bht_upd_taken && bht[bht_upd_idx] != 2'd0) begin
                bht[bht_upd_idx] <= bht[bht_upd_idx] - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            pc            <= RESET_PC;
            if_inst       <= NOP_WORD;
            if_pc         <= RESET_PC;
            if_pred_taken <= 1'b0;
        end else if (redirect) begin
            pc            <= redirect_pc;
            if_inst       <= NOP_WORD;
            if_pred_taken <= 1'b0;
        end else if (!stall) begin
            pc            <= next_pc;
            if_inst       <= f_inst;
            if_pc         <= pc;
            if_pred_taken <= pred;
        end
    end

endmodule

// File: source/decode_unit.sv
`timescale 1ns/10ps

module decode_unit
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        reg_we,
    input  logic [4:0]  reg_addr,
    input  logic [31:0] reg_data,
    input  logic [31:0] if_inst,
    input  logic [31:0] if_pc,
    input  logic        if_pred_taken,
    input  logic        redirect,
    input  logic        wb_en,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data,
    output logic        stall,
    output logic [31:0] id_pc,
    output logic [31:0] id_rs1_val,
    output logic [31:0] id_rs2_val,
    output logic [4:0]  id_rs1,
    output logic [4:0]  id_rs2,
    output logic [4:0]  id_rd,
    output logic [31:0] id_imm,
    output logic [2:0]  id_alu_op,
    output logic        id_alu_src,
    output logic        id_mem_read,
    output logic        id_mem_write,
    output logic        id_reg_write,
    output logic        id_branch,
    output logic        id_branch_ne,
    output logic        id_pred_taken
);

    logic [31:0] rf [32];
    inst_word_u  d;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm;
    logic [2:0]  alu_op;
    logic        alu_src;
    logic        mem_read;
    logic        mem_write;
    logic        reg_write;
    logic        branch;

    assign d = if_inst;

    always_ff @(posedge clk) begin
        if (reg_we && reg_addr != 5'd0) begin
            rf[reg_addr] <= reg_data;
        end else if (wb_en && wb_rd != 5'd0) begin
            rf[wb_rd] <= wb_data;
        end
    end

    // Write-first read, x0 reads as zero
    assign rs1_val = (d.r.rs1 == 5'd0) ? 32'd0 :
                     (wb_en && wb_rd == d.r.rs1) ? wb_data : rf[d.r.rs1];
    assign rs2_val = (d.r.rs2 == 5'd0) ? 32'd0 :
                     (wb_en && wb_rd == d.r.rs2) ? wb_data : rf[d.r.rs2];

    always_comb begin
        imm       = {{20{d.r.funct7[6]}}, d.r.funct7, d.r.rs2};
        alu_op    = ALU_ADD;
        alu_src   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        branch    = 1'b0;
        case (d.r.opcode)
            OPC_OP: begin
                reg_write = 1'b1;
                case (d.r.funct3)
                    F3_ADD_SUB: alu_op = (d.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: ;
                endcase
            end
            OPC_OP_IMM: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            OPC_LOAD: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            OPC_STORE: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm       = {{20{d.sb.imm_hi[6]}}, d.sb.imm_hi, d.sb.imm_lo};
            end
            OPC_BRANCH: begin
                branch = 1'b1;
                imm    = {{20{d.sb.imm_hi[6]}}, d.sb.imm_lo[0], d.sb.imm_hi[5:0],
                          d.sb.imm_lo[4:1], 1'b0};
            end
            default: ;
        endcase
    end

    // Load in EX whose result the decoding word needs
    assign stall = id_mem_read && id_rd != 5'd0 &&
                   (id_rd == d.r.rs1 || id_rd == d.r.rs2);

    always_ff @(posedge clk) begin
        if (rst || redirect || stall) begin
            id_rd         <= 5'd0;
            id_mem_read   <= 1'b0;
            id_mem_write  <= 1'b0;
            id_reg_write  <= 1'b0;
            id_branch     <= 1'b0;
            id_pred_taken <= 1'b0;
        end else begin
            id_rd         <= d.r.rd;
            id_mem_read   <= mem_read;
            id_mem_write  <= mem_write;
            id_reg_write  <= reg_write;
            id_branch     <= branch;
            id_pred_taken <= if_pred_taken;
        end
    end

    always_ff @(posedge clk) begin
        id_pc        <= if_pc;
        id_rs1_val   <= rs1_val;
        id_rs2_val   <= rs2_val;
        id_rs1       <= d.r.rs1;
        id_rs2       <= d.r.rs2;
        id_imm       <= imm;
        id_alu_op    <= alu_op;
        id_alu_src   <= alu_src;
        id_branch_ne <= (d.r.funct3 == F3_BNE);
    end

endmodule

// File: source/execute_unit.sv
`timescale 1ns/10ps

module execute_unit
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [31:0]       id_pc,
    input  logic [31:0]       id_rs1_val,
    input  logic [31:0]       id_rs2_val,
    input  logic [4:0]        id_rs1,
    input  logic [4:0]        id_rs2,
    input  logic [4:0]        id_rd,
    input  logic [31:0]       id_imm,
    input  logic [2:0]        id_alu_op,
    input  logic              id_alu_src,
    input  logic              id_mem_read,
    input  logic              id_mem_write,
    input  logic              id_reg_write,
    input  logic              id_branch,
    input  logic              id_branch_ne,
    input  logic              id_pred_taken,
    input  logic              wb_en,
    input  logic [4:0]        wb_rd,
    input  logic [31:0]       wb_data,
    output logic              redirect,
    output logic [31:0]       redirect_pc,
    output logic              bht_upd,
    output logic [BHT_AW-1:0] bht_upd_idx,
    output logic              bht_upd_taken,
    output logic [31:0]       ex_alu_result,
    output logic [31:0]       ex_store_data,
    output logic [4:0]        ex_rd,
    output logic              ex_mem_read,
    output logic              ex_mem_write,
    output logic              ex_reg_write
);

    logic [31:0] fwd_a;
    logic [31:0] fwd_b;
    logic [31:0] opnd_b;
    logic [31:0] result;
    logic        taken;

    // EX/MEM first, then MEM/WB
    always_comb begin
        if (ex_reg_write && ex_rd != 5'd0 && ex_rd == id_rs1) begin
            fwd_a = ex_alu_result;
        end else if (wb_en && wb_rd != 5'd0 && wb_rd == id_rs1) begin
            fwd_a = wb_data;
        end else begin
            fwd_a = id_rs1_val;
        end
        if (ex_reg_write && ex_rd != 5'd0 && ex_rd == id_rs2) begin
            fwd_b = ex_alu_result;
        end else if (wb_en && wb_rd != 5'd0 && wb_rd == id_rs2) begin
            fwd_b = wb_data;
        end else begin
            fwd_b = id_rs2_val;
        end
    end

    assign opnd_b = id_alu_src ? id_imm : fwd_b;

    always_comb begin
        case (id_alu_op)
            ALU_SUB: result = fwd_a - opnd_b;
            ALU_AND: result = fwd_a & opnd_b;
            ALU_OR:  result = fwd_a | opnd_b;
            ALU_XOR: result = fwd_a ^ opnd_b;
            default: result = fwd_a + opnd_b;
        endcase
    end

    assign taken = id_branch_ne ? (fwd_a != fwd_b) : (fwd_a == fwd_b);

    // Fix up only when the prediction was wrong
    assign redirect      = id_branch && (taken != id_pred_taken);
    assign redirect_pc   = taken ? id_pc + id_imm : id_pc + 32'd4;
    assign bht_upd       = id_branch;
    assign bht_upd_idx   = id_pc[BHT_AW+1:2];
    assign bht_upd_taken = taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_rd        <= 5'd0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end else begin
            ex_rd        <= id_rd;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
            ex_reg_write <= id_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_result <= result;
        ex_store_data <= fwd_b;
    end

endmodule

// File: source/memory_writeback.sv
`timescale 1ns/10ps

module memory_writeback
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               dmem_we,
    input  logic [DMEM_AW-1:0] dmem_addr,
    input  logic [31:0]        dmem_data,
    input  logic [31:0]        ex_alu_result,
    input  logic [31:0]        ex_store_data,
    input  logic [4:0]         ex_rd,
    input  logic               ex_mem_read,
    input  logic               ex_mem_write,
    input  logic               ex_reg_write,
    output logic               sync_wr,
    output logic [31:0]        sync_addr,
    output logic [31:0]        sync_data,
    output logic               wb_en,
    output logic [4:0]         wb_rd,
    output logic [31:0]        wb_data
);

    logic [31:0] dmem [2**DMEM_AW];
    logic [31:0] load_q;
    logic [31:0] alu_q;
    logic        is_load_q;

    always_ff @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_data;
        end else if (ex_mem_write) begin
            dmem[ex_alu_result[DMEM_AW+1:2]] <= ex_store_data;
        end
    end

    // Every store in this stage is mirrored out
    assign sync_wr   = ex_mem_write;
    assign sync_addr = ex_alu_result;
    assign sync_data = ex_store_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en     <= 1'b0;
            wb_rd     <= 5'd0;
            is_load_q <= 1'b0;
        end else begin
            wb_en     <= ex_reg_write;
            wb_rd     <= ex_rd;
            is_load_q <= ex_mem_read;
        end
    end

    always_ff @(posedge clk) begin
        load_q <= dmem[ex_alu_result[DMEM_AW+1:2]];
        alu_q  <= ex_alu_result;
    end

    assign wb_data = is_load_q ? load_q : alu_q;

endmodule

// File: source/cpu_top.sv
`timescale 1ns/10ps

module cpu_top
    import core_cfg_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  logic               imem_we,
    input  logic [IMEM_AW-1:0] imem_addr,
    input  logic [31:0]        imem_data,
    input  logic               reg_we,
    input  logic [4:0]         reg_addr,
    input  logic [31:0]        reg_data,
    input  logic               bht_we,
    input  logic [BHT_AW-1:0]  bht_addr,
    input  logic [1:0]         bht_data,
    input  logic               dmem_we,
    input  logic [DMEM_AW-1:0] dmem_addr,
    input  logic [31:0]        dmem_data,
    output logic               sync_wr,
    output logic [31:0]        sync_addr,
    output logic [31:0]        sync_data
);

    // IF/ID
    logic [31:0]       if_inst;
    logic [31:0]       if_pc;
    logic              if_pred_taken;
    // ID/EX
    logic              stall;
    logic [31:0]       id_pc;
    logic [31:0]       id_rs1_val;
    logic [31:0]       id_rs2_val;
    logic [4:0]        id_rs1;
    logic [4:0]        id_rs2;
    logic [4:0]        id_rd;
    logic [31:0]       id_imm;
    logic [2:0]        id_alu_op;
    logic              id_alu_src;
    logic              id_mem_read;
    logic              id_mem_write;
    logic              id_reg_write;
    logic              id_branch;
    logic              id_branch_ne;
    logic              id_pred_taken;
    // Branch resolution back to fetch
    logic              redirect;
    logic [31:0]       redirect_pc;
    logic              bht_upd;
    logic [BHT_AW-1:0] bht_upd_idx;
    logic              bht_upd_taken;
    // EX/MEM
    logic [31:0]       ex_alu_result;
    logic [31:0]       ex_store_data;
    logic [4:0]        ex_rd;
    logic              ex_mem_read;
    logic              ex_mem_write;
    logic              ex_reg_write;
    // Writeback
    logic              wb_en;
    logic [4:0]        wb_rd;
    logic [31:0]       wb_data;

    fetch_unit u_fetch (.*);

    decode_unit u_decode (.*);

    execute_unit u_execute (.*);

    memory_writeback u_mem_wb (.*);

endmodule

// File: include/test_program.svh
`ifndef TEST_PROGRAM_SVH
`define TEST_PROGRAM_SVH

localparam int PROG_LEN = 29;

// Preloaded data words at byte 0x80 and 0x84
localparam logic [31:0] DATA0 = 32'h1234_5678;
localparam logic [31:0] DATA1 = 32'h0F0F_0F0F;

localparam logic [31:0] PROG [PROG_LEN] = '{
    {7'b0000000, 5'd2, 5'd1, 3'b000, 5'd5, 7'b0110011},   // add  x5, x1, x2
    {7'b0100000, 5'd3, 5'd5, 3'b000, 5'd6, 7'b0110011},   // sub  x6, x5, x3
    {7'b0000000, 5'd4, 5'd1, 3'b111, 5'd7, 7'b0110011},   // and  x7, x1, x4
    {7'b0000000, 5'd7, 5'd6, 3'b110, 5'd8, 7'b0110011},   // or   x8, x6, x7
    {7'b0000000, 5'd2, 5'd8, 3'b100, 5'd9, 7'b0110011},   // xor  x9, x8, x2
    {12'hFFB, 5'd9, 3'b000, 5'd10, 7'b0010011},            // addi x10, x9, -5
    {7'b0001000, 5'd5, 5'd0, 3'b010, 5'b00000, 7'b0100011}, // sw x5, 0x100
    {7'b0001000, 5'd6, 5'd0, 3'b010, 5'b00100, 7'b0100011}, // sw x6, 0x104
    {7'b0001000, 5'd7, 5'd0, 3'b010, 5'b01000, 7'b0100011}, // sw x7, 0x108
    {7'b0001000, 5'd8, 5'd0, 3'b010, 5'b01100, 7'b0100011}, // sw x8, 0x10c
    {7'b0001000, 5'd9, 5'd0, 3'b010, 5'b10000, 7'b0100011}, // sw x9, 0x110
    {7'b0001000, 5'd10, 5'd0, 3'b010, 5'b10100, 7'b0100011}, // sw x10, 0x114
    {12'h080, 5'd0, 3'b010, 5'd11, 7'b0000011},             // lw   x11, 0x80
    {12'h001, 5'd11, 3'b000, 5'd12, 7'b0010011},            // addi x12, x11, 1
    {12'h084, 5'd0, 3'b010, 5'd13, 7'b0000011},             // lw   x13, 0x84
    {7'b0001000, 5'd12, 5'd0, 3'b010, 5'b11000, 7'b0100011}, // sw x12, 0x118
    {7'b0001000, 5'd13, 5'd0, 3'b010, 5'b11100, 7'b0100011}, // sw x13, 0x11c
    {12'h003, 5'd0, 3'b000, 5'd14, 7'b0010011},             // addi x14, x0, 3
    {12'h000, 5'd0, 3'b000, 5'd15, 7'b0010011},             // addi x15, x0, 0
    {12'h001, 5'd15, 3'b000, 5'd15, 7'b0010011},            // loop: addi x15, x15, 1
    {7'b0001001, 5'd15, 5'd0, 3'b010, 5'b00000, 7'b0100011}, // sw x15, 0x120
    {7'b0000000, 5'd14, 5'd15, 3'b000, 5'b01000, 7'b1100011}, // beq x15, x14, +8
    {7'b1111111, 5'd0, 5'd0, 3'b000, 5'b10101, 7'b1100011},  // beq x0, x0, loop
    {7'b0000000, 5'd14, 5'd15, 3'b001, 5'b01000, 7'b1100011}, // bne x15, x14, +8
    {7'b0001001, 5'd15, 5'd0, 3'b010, 5'b00100, 7'b0100011}, // sw x15, 0x124 kept
    {7'b0000000, 5'd0, 5'd15, 3'b001, 5'b01000, 7'b1100011},  // bne x15, x0, +8
    {7'b0001001, 5'd1, 5'd0, 3'b010, 5'b01000, 7'b0100011},  // sw x1, 0x128 skipped
    {7'b0001001, 5'd14, 5'd0, 3'b010, 5'b01100, 7'b0100011}, // sw x14, 0x12c
    {7'b0000000, 5'd0, 5'd0, 3'b000, 5'b00000, 7'b1100011}   // beq x0, x0, 0 (halt)
};

// Entries below EXP_SEEDED depend on x1..x4 (a=x1+x2, b=a-x3, c=x1&x4,
// d=b|c, e=d^x2, f=e-5); EXP_CONST holds the data of the rest
localparam int EXP_LEN    = 13;
localparam int EXP_SEEDED = 6;

localparam logic [31:0] EXP_ADDR [EXP_LEN] = '{
    32'h100, 32'h104, 32'h108, 32'h10c, 32'h110, 32'h114,
    32'h118, 32'h11c, 32'h120, 32'h120, 32'h120, 32'h124, 32'h12c
};

localparam logic [31:0] EXP_CONST [EXP_LEN] = '{
    32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0,
    DATA0 + 32'd1, DATA1, 32'd1, 32'd2, 32'd3, 32'd3, 32'd3
};

`endif

// File: testbench/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb
    import core_cfg_pkg::*;
();

    `include "test_program.svh"

    // Generous bound on load, run and drain time
    localparam int TIMEOUT_CYCLES = PROG_LEN * 8 + 200;
    localparam int DRAIN_CYCLES   = 40;

    logic               clk;
    logic               rst;
    logic               run;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    logic [31:0]        imem_data;
    logic               reg_we;
    logic [4:0]         reg_addr;
    logic [31:0]        reg_data;
    logic               bht_we;
    logic [BHT_AW-1:0]  bht_addr;
    logic [1:0]         bht_data;
    logic               dmem_we;
    logic [DMEM_AW-1:0] dmem_addr;
    logic [31:0]        dmem_data;
    logic               sync_wr;
    logic [31:0]        sync_addr;
    logic [31:0]        sync_data;

    int          seed;
    logic [31:0] xreg [1:4];
    int          error_cnt;
    int          store_cnt;
    int          cycle_cnt = 0;

    cpu_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, only %0d of %0d stores seen",
                     cycle_cnt, store_cnt, EXP_LEN);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Store data per RV32I rules on the seeded x1..x4
    function automatic logic [31:0] expected_data(int idx);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        if (idx >= EXP_SEEDED) begin
            return EXP_CONST[idx];
        end
        a = xreg[1] + xreg[2];
        b = a - xreg[3];
        c = xreg[1] & xreg[4];
        d = b | c;
        e = d ^ xreg[2];
        case (idx)
            0:       return a;
            1:       return b;
            2:       return c;
            3:       return d;
            4:       return e;
            default: return e - 32'd5;
        endcase
    endfunction

    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge clk);
            imem_we   = 1'b1;
            imem_addr = IMEM_AW'(i);
            imem_data = PROG[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
    endtask

    task automatic seed_registers();
        for (int r = 1; r <= 4; r++) begin
            @(negedge clk);
            xreg[r]  = $random(seed);
            reg_we   = 1'b1;
            reg_addr = 5'(r);
            reg_data = xreg[r];
        end
        @(negedge clk);
        reg_we = 1'b0;
    endtask

    // All counters strongly not taken
    task automatic clear_history();
        for (int i = 0; i < 2**BHT_AW; i++) begin
            @(negedge clk);
            bht_we   = 1'b1;
            bht_addr = BHT_AW'(i);
            bht_data = 2'd0;
        end
        @(negedge clk);
        bht_we = 1'b0;
    endtask

    task automatic preload_data();
        @(negedge clk);
        dmem_we   = 1'b1;
        dmem_addr = DMEM_AW'(32'h80 >> 2);
        dmem_data = DATA0;
        @(negedge clk);
        dmem_addr = DMEM_AW'(32'h84 >> 2);
        dmem_data = DATA1;
        @(negedge clk);
        dmem_we = 1'b0;
    endtask

    task automatic check_store();
        logic [31:0] exp_data;
        exp_data = expected_data(store_cnt);
        assert (sync_addr == EXP_ADDR[store_cnt] && sync_data == exp_data) else begin
            error_cnt++;
            $display("[FAIL] %0t: store %0d wrote %h to %h, expected %h to %h",
                     $time, store_cnt, sync_data, sync_addr, exp_data, EXP_ADDR[store_cnt]);
        end
        store_cnt++;
    endtask

    initial begin
        rst       = 1'b1;
        run       = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_data  = '0;
        bht_we    = 1'b0;
        bht_addr  = '0;
        bht_data  = '0;
        dmem_we   = 1'b0;
        dmem_addr = '0;
        dmem_data = '0;
        seed      = 32'h71d0203b;
        error_cnt = 0;
        store_cnt = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        load_program();
        seed_registers();
        clear_history();
        preload_data();
        @(negedge clk);
        run = 1'b1;

        // Walk the expected store table as strobes arrive
        while (store_cnt < EXP_LEN) begin
            @(negedge clk);
            if (sync_wr) begin
                check_store();
            end
        end

        // Halt loop spins here, nothing more may be stored
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            if (sync_wr) begin
                store_cnt++;
                $display("Extra store of %h to %h at %0t after the last expected store",
                         sync_data, sync_addr, $time);
            end
        end
        assert (store_cnt == EXP_LEN) else begin
            error_cnt++;
            $display("Saw %0d stores but expected exactly %0d", store_cnt, EXP_LEN);
        end

        $display("Errors: %0d, stores seen: %0d of %0d", error_cnt, store_cnt, EXP_LEN);
        if (error_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
source/rv_isa_pkg.sv
source/core_cfg_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/memory_writeback.sv
source/cpu_top.sv
testbench/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module cpu_tb -o cpu_tb_sim
./obj_dir/cpu_tb_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
